// File: rtl/msx_macros.svh
`ifndef MSX_MACROS_SVH
`define MSX_MACROS_SVH

// one VRAM bank is 64 KB
`define VRAM_ADDR_WIDTH 16

// low and high 64 KB bank
`define VRAM_BANKS 2

// Z80 I/O ports of the VDP
`define VDP_DATA_PORT 8'h98
`define VDP_CTRL_PORT 8'h99

// TMS9918 wraps at 16 KB
`define TMS_ADDR_WIDTH 14

`endif

// File: rtl/msx_pkg.sv
`include "msx_macros.svh"

package msx_pkg;

   typedef logic [7:0] byte_t;

   typedef logic [15:0] io_addr_t;

   typedef logic [`VRAM_ADDR_WIDTH-1:0] vram_addr_t;

   // machine generation
   typedef enum logic {
      MSX1 = 1'b0,
      MSX2 = 1'b1
   } machine_t;

   typedef struct packed {
      machine_t typ;
   } config_t;

   // one VRAM access as issued by a port core
   typedef struct packed {
      vram_addr_t address;
      byte_t      data;
      logic       we_lo;
      logic       we_hi;
   } vram_req_t;

endpackage

// File: rtl/vram_bank.sv
`include "msx_macros.svh"

module vram_bank (
   input  logic               clk21m,
   input  msx_pkg::vram_addr_t address,
   input  logic               wren,
   input  msx_pkg::byte_t     data,
   output msx_pkg::byte_t     q
);
   import msx_pkg::*;

   byte_t mem [0:(1 << `VRAM_ADDR_WIDTH)-1];

   // registered read, old data on a write cycle
   always_ff @(posedge clk21m) begin
      if (wren) begin
         mem[address] <= data;
      end
      q <= mem[address];
   end

endmodule

// File: rtl/vdp_port_tms.sv
`include "msx_macros.svh"

module vdp_port_tms (
   input  logic                clk21m,
   input  logic                reset,
   input  msx_pkg::io_addr_t   addr,
   input  msx_pkg::byte_t      d_from_cpu,
   output msx_pkg::byte_t      d_to_cpu,
   output logic                data_bus_rq,
   input  logic                wr_n,
   input  logic                rd_n,
   input  logic                iorq_n,
   input  logic                mreq_n,
   input  logic                m1_n,
   output msx_pkg::vram_req_t  vram_req,
   input  msx_pkg::byte_t      vram_di
);
   import msx_pkg::*;

   logic                       io_sel;
   logic                       data_wr;
   logic                       data_rd;
   logic                       ctrl_wr;
   logic                       rd_start;
   logic [`TMS_ADDR_WIDTH-1:0] vram_addr;
   logic                       toggle;
   byte_t                      latch;
   byte_t                      wr_data;
   logic                       wr_pend;
   logic                       rd_pend;
   logic                       rd_load;
   byte_t                      rd_buf;

   // plain I/O cycle, no memory or opcode fetch
   assign io_sel  = ~iorq_n & mreq_n & m1_n;
   assign data_wr = io_sel & ~wr_n & (addr[7:0] == `VDP_DATA_PORT);
   assign data_rd = io_sel & ~rd_n & (addr[7:0] == `VDP_DATA_PORT);
   assign ctrl_wr = io_sel & ~wr_n & (addr[7:0] == `VDP_CTRL_PORT);

   // data port read or read address setup
   assign rd_start = data_rd | (ctrl_wr & toggle & (d_from_cpu[7:6] == 2'b00));

   assign d_to_cpu    = rd_buf;
   assign data_bus_rq = data_rd;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         vram_addr <= '0;
         toggle    <= 1'b0;
         wr_pend   <= 1'b0;
         rd_pend   <= 1'b0;
         rd_load   <= 1'b0;
         rd_buf    <= '0;
      end else begin
         wr_pend <= data_wr;
         rd_pend <= rd_start;
         rd_load <= rd_pend;
         if (data_wr | data_rd) begin
            toggle <= 1'b0;
         end
         if (ctrl_wr) begin
            toggle <= ~toggle;
            // register writes have no effect here
            if (toggle && !d_from_cpu[7]) begin
               vram_addr <= {d_from_cpu[5:0], latch};
            end
         end else if (wr_pend | rd_pend) begin
            vram_addr <= vram_addr + 1'b1;
         end
         if (rd_load) begin
            rd_buf <= vram_di;
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (ctrl_wr && !toggle) begin
         latch <= d_from_cpu;
      end
      if (data_wr) begin
         wr_data <= d_from_cpu;
      end
   end

   // low bank only
   assign vram_req.address = vram_addr_t'(vram_addr);
   assign vram_req.data    = wr_data;
   assign vram_req.we_lo   = wr_pend;
   assign vram_req.we_hi   = 1'b0;

endmodule

// File: rtl/vdp_port_v9938.sv
`include "msx_macros.svh"

module vdp_port_v9938 (
   input  logic                clk21m,
   input  logic                reset,
   input  msx_pkg::io_addr_t   addr,
   input  msx_pkg::byte_t      d_from_cpu,
   output msx_pkg::byte_t      d_to_cpu,
   output logic                data_bus_rq,
   input  logic                wr_n,
   input  logic                rd_n,
   input  logic                iorq_n,
   input  logic                mreq_n,
   input  logic                m1_n,
   output msx_pkg::vram_req_t  vram_req,
   input  msx_pkg::byte_t      vram_di_lo,
   input  msx_pkg::byte_t      vram_di_hi
);
   import msx_pkg::*;

   logic                       io_sel;
   logic                       data_wr;
   logic                       data_rd;
   logic                       ctrl_wr;
   logic                       rd_start;
   logic [`TMS_ADDR_WIDTH-1:0] addr_lo;
   logic [2:0]                 reg14;
   logic [16:0]                vaddr;
   logic                       toggle;
   byte_t                      latch;
   byte_t                      wr_data;
   logic                       wr_pend;
   logic                       rd_pend;
   logic                       rd_load;
   logic                       rd_bank;
   byte_t                      rd_buf;

   assign io_sel  = ~iorq_n & mreq_n & m1_n;
   assign data_wr = io_sel & ~wr_n & (addr[7:0] == `VDP_DATA_PORT);
   assign data_rd = io_sel & ~rd_n & (addr[7:0] == `VDP_DATA_PORT);
   assign ctrl_wr = io_sel & ~wr_n & (addr[7:0] == `VDP_CTRL_PORT);

   assign rd_start = data_rd | (ctrl_wr & toggle & (d_from_cpu[7:6] == 2'b00));

   // r14 supplies address bits 16 to 14
   assign vaddr = {reg14, addr_lo};

   assign d_to_cpu    = rd_buf;
   assign data_bus_rq = data_rd;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         addr_lo <= '0;
         reg14   <= '0;
         toggle  <= 1'b0;
         wr_pend <= 1'b0;
         rd_pend <= 1'b0;
         rd_load <= 1'b0;
         rd_buf  <= '0;
      end else begin
         wr_pend <= data_wr;
         rd_pend <= rd_start;
         rd_load <= rd_pend;
         if (data_wr | data_rd) begin
            toggle <= 1'b0;
         end
         if (ctrl_wr) begin
            toggle <= ~toggle;
            if (toggle) begin
               if (!d_from_cpu[7]) begin
                  addr_lo <= {d_from_cpu[5:0], latch};
               end else if (d_from_cpu[5:0] == 6'd14) begin
                  reg14 <= latch[2:0];
               end
            end
         end else if (wr_pend | rd_pend) begin
            // carry runs on into r14
            {reg14, addr_lo} <= vaddr + 17'd1;
         end
         if (rd_load) begin
            rd_buf <= rd_bank ? vram_di_hi : vram_di_lo;
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (ctrl_wr && !toggle) begin
         latch <= d_from_cpu;
      end
      if (data_wr) begin
         wr_data <= d_from_cpu;
      end
      // bank of the prefetch in flight
      if (rd_pend) begin
         rd_bank <= vaddr[16];
      end
   end

   assign vram_req.address = vaddr[15:0];
   assign vram_req.data    = wr_data;
   assign vram_req.we_lo   = wr_pend & ~vaddr[16];
   assign vram_req.we_hi   = wr_pend & vaddr[16];

endmodule

// File: rtl/msx_select.sv
`include "msx_macros.svh"

module msx_select (
   input  msx_pkg::config_t  msx_conf,
   input  logic              clk21m,
   input  logic              reset,
   input  msx_pkg::io_addr_t addr,
   input  msx_pkg::byte_t    d_from_cpu,
   output msx_pkg::byte_t    d_to_cpu,
   output logic              data_bus_rq,
   input  logic              wr_n,
   input  logic              rd_n,
   input  logic              iorq_n,
   input  logic              mreq_n,
   input  logic              m1_n
);
   import msx_pkg::*;

   logic                   is_msx1;
   logic                   tms_wr_n;
   logic                   v9938_wr_n;
   byte_t                  tms_d_to_cpu;
   byte_t                  v9938_d_to_cpu;
   logic                   tms_bus_rq;
   logic                   v9938_bus_rq;
   vram_req_t              tms_req;
   vram_req_t              v9938_req;
   vram_req_t              vram_req;
   logic [`VRAM_BANKS-1:0] bank_we;
   byte_t                  bank_q [`VRAM_BANKS];

   assign is_msx1 = (msx_conf.typ == MSX1);

   // inactive core sees no writes and keeps its state
   assign tms_wr_n   = ~is_msx1 | wr_n;
   assign v9938_wr_n = is_msx1 | wr_n;

   assign d_to_cpu    = is_msx1 ? tms_d_to_cpu : v9938_d_to_cpu;
   assign data_bus_rq = is_msx1 ? tms_bus_rq   : v9938_bus_rq;
   assign vram_req    = is_msx1 ? tms_req      : v9938_req;

   assign bank_we = {vram_req.we_hi, vram_req.we_lo};

   vdp_port_tms tms_i (
      .clk21m      (clk21m),
      .reset       (reset),
      .addr        (addr),
      .d_from_cpu  (d_from_cpu),
      .d_to_cpu    (tms_d_to_cpu),
      .data_bus_rq (tms_bus_rq),
      .wr_n        (tms_wr_n),
      .rd_n        (rd_n),
      .iorq_n      (iorq_n),
      .mreq_n      (mreq_n),
      .m1_n        (m1_n),
      .vram_req    (tms_req),
      .vram_di     (bank_q[0])
   );

   vdp_port_v9938 v9938_i (
      .clk21m      (clk21m),
      .reset       (reset),
      .addr        (addr),
      .d_from_cpu  (d_from_cpu),
      .d_to_cpu    (v9938_d_to_cpu),
      .data_bus_rq (v9938_bus_rq),
      .wr_n        (v9938_wr_n),
      .rd_n        (rd_n),
      .iorq_n      (iorq_n),
      .mreq_n      (mreq_n),
      .m1_n        (m1_n),
      .vram_req    (v9938_req),
      .vram_di_lo  (bank_q[0]),
      .vram_di_hi  (bank_q[1])
   );

   // bank 0 low 64 KB, bank 1 high 64 KB
   for (genvar i = 0; i < `VRAM_BANKS; i++) begin : gen_bank
      vram_bank bank_g (
         .clk21m  (clk21m),
         .address (vram_req.address),
         .wren    (bank_we[i]),
         .data    (vram_req.data),
         .q       (bank_q[i])
      );
   end

endmodule

// File: sim/tb_msx_select.sv
`include "msx_macros.svh"

module tb_msx_select;
   timeunit 1ns;
   timeprecision 100ps;

   import msx_pkg::*;

   localparam string CASE_FILE = "sim/vdp_cases.txt";

   config_t     msx_conf;
   logic        clk21m;
   logic        reset;
   io_addr_t    addr;
   byte_t       d_from_cpu;
   byte_t       d_to_cpu;
   logic        data_bus_rq;
   logic        wr_n;
   logic        rd_n;
   logic        iorq_n;
   logic        mreq_n;
   logic        m1_n;

   int          test_errors;
   int          tests_passed;
   int          tests_failed;
   int unsigned cycles;
   int unsigned cycle_limit;

   msx_select dut_i (.*);

   initial clk21m = 1'b0;
   always #4 clk21m = ~clk21m;

   // run length guard armed once the case file is counted
   always @(posedge clk21m) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("run stopped at cycle %0d because the case file did not finish in time", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   // one strobe cycle followed by 7 idle cycles
   task automatic io_write(input byte_t port, input byte_t data);
      @(posedge clk21m);
      #1;
      addr       = {8'h00, port};
      d_from_cpu = data;
      iorq_n     = 1'b0;
      wr_n       = 1'b0;
      @(posedge clk21m);
      #1;
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      repeat (6) @(posedge clk21m);
   endtask

   task automatic io_read(input byte_t port, output byte_t data, output logic bus_rq);
      @(posedge clk21m);
      #1;
      addr   = {8'h00, port};
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      // outputs settled half a cycle after the edge
      #3;
      data   = d_to_cpu;
      bus_rq = data_bus_rq;
      @(posedge clk21m);
      #1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      repeat (6) @(posedge clk21m);
   endtask

   task automatic check_value(input string name, input byte_t expected, input byte_t actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %02h, actual %02h", name, expected, actual);
         test_errors++;
      end
   endtask

   initial begin
      int         fd;
      int         n_lines;
      int         n;
      string      line;
      string      name;
      string      op;
      logic [7:0] arg_a;
      logic [7:0] arg_b;
      byte_t      rd_data;
      logic       rd_rq;

      msx_conf.typ = MSX1;
      reset        = 1'b1;
      addr         = '0;
      d_from_cpu   = '0;
      wr_n         = 1'b1;
      rd_n         = 1'b1;
      iorq_n       = 1'b1;
      mreq_n       = 1'b1;
      m1_n         = 1'b1;
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      cycles       = 0;
      cycle_limit  = 0;

      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         $display("could not open the case file %s", CASE_FILE);
         $display("Verification failed");
         $finish;
      end else begin
         n_lines = 0;
         while ($fgets(line, fd) != 0) begin
            n_lines++;
         end
         $fclose(fd);
         cycle_limit = 8 * n_lines + 16 + 200;

         repeat (16) @(posedge clk21m);
         #1;
         reset = 1'b0;

         fd = $fopen(CASE_FILE, "r");
         while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %s %h %h", name, op, arg_a, arg_b);
            if (n < 1 || name.substr(0, 0) == "#") begin
               continue;
            end
            if (n != 4) begin
               $display("%s: a line of the case file is missing fields", name);
               test_errors++;
               continue;
            end
            if (op == "M") begin
               @(posedge clk21m);
               #1;
               msx_conf.typ = (arg_a == 8'h02) ? MSX2 : MSX1;
            end else if (op == "W") begin
               io_write(arg_a, arg_b);
            end else if (op == "R") begin
               io_read(arg_a, rd_data, rd_rq);
               if (arg_a == `VDP_DATA_PORT) begin
                  check_value(name, arg_b, rd_data);
                  if (!rd_rq) begin
                     $display("%s: the bus request was missing on a read of port 98h", name);
                     test_errors++;
                  end
               end else if (rd_rq) begin
                  $display("%s: the bus request was raised for port %02h", name, arg_a);
                  test_errors++;
               end
            end else if (op == "E") begin
               if (test_errors == 0) begin
                  $display("PASS %s", name);
                  tests_passed++;
               end else begin
                  $display("FAIL %s with %0d errors", name, test_errors);
                  tests_failed++;
               end
               test_errors = 0;
            end else begin
               $display("%s: unknown operation %s in the case file", name, op);
               test_errors++;
            end
         end
         $fclose(fd);
         if (test_errors != 0) begin
            $display("the case file ended inside a test that had errors");
            tests_failed++;
         end

         $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
         if (tests_failed == 0) begin
            $display("Verification passed");
         end else begin
            $display("Verification failed");
         end
         $finish;
      end
   end

endmodule

// File: sim/vdp_cases.txt
# test op a b (hex): M a=1 or 2 machine, W a=port b=data, R a=port b=expected, E ends the test
# an R of a port other than 98h only checks that data_bus_rq stays low
msx1_rt M 1 00
msx1_rt W 99 fe
msx1_rt W 99 7f
msx1_rt W 98 11
msx1_rt W 98 22
msx1_rt W 98 33
msx1_rt W 99 fe
msx1_rt W 99 3f
msx1_rt R 98 11
msx1_rt R 98 22
msx1_rt R 98 33
msx1_rt E 00 00
msx1_wrap W 99 00
msx1_wrap W 99 00
msx1_wrap R 98 33
msx1_wrap E 00 00
msx2_bank M 2 00
msx2_bank W 99 04
msx2_bank W 99 8e
msx2_bank W 99 00
msx2_bank W 99 40
msx2_bank W 98 b1
msx2_bank W 99 00
msx2_bank W 99 00
msx2_bank R 98 b1
msx2_bank W 99 00
msx2_bank W 99 8e
msx2_bank W 99 00
msx2_bank W 99 00
msx2_bank R 98 33
msx2_bank E 00 00
msx2_carry W 99 03
msx2_carry W 99 8e
msx2_carry W 99 ff
msx2_carry W 99 7f
msx2_carry W 98 c1
msx2_carry W 98 c2
msx2_carry W 99 00
msx2_carry W 99 00
msx2_carry R 98 c2
msx2_carry E 00 00
machine_sw M 1 00
machine_sw W 99 01
machine_sw W 99 40
machine_sw W 98 d1
machine_sw M 2 00
machine_sw W 98 d2
machine_sw M 1 00
machine_sw W 98 d3
machine_sw W 99 01
machine_sw W 99 00
machine_sw R 98 d1
machine_sw R 98 d3
machine_sw E 00 00
bus_rq R a8 00
bus_rq E 00 00

// File: flist.f
+incdir+rtl
rtl/msx_pkg.sv
rtl/vram_bank.sv
rtl/vdp_port_tms.sv
rtl/vdp_port_v9938.sv
rtl/msx_select.sv
sim/tb_msx_select.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MSX VRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f flist.f --top-module tb_msx_select -o tb_msx_select
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_msx_select > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Verification passed$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
